//--- Bender.yml
package:
  name: acc_cpu

sources:
  - design/cpu_pkg.sv
  - design/prog_mem.sv
  - design/seq_control.sv
  - design/exec_unit.sv
  - design/reg_file.sv
  - design/ret_stack.sv
  - design/cpu_top.sv
  - target: test
    files:
      - verif/tb_cpu.sv

//--- design/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Accumulator and register data
  localparam int DATA_W  = 8;
  // Program address, also sets memory depth and stack payload
  localparam int PADDR_W = 4;
  // One instruction word: opcode, mode, a, b
  localparam int INSTR_W = 16;
  // Register file index
  localparam int RADDR_W = 4;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Top nibble of the instruction; values above OP_RTN decode as NOP
  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_LD  = 4'd6,
    OP_ST  = 4'd7,
    OP_JMP = 4'd8,
    OP_RTN = 4'd9
  } opcode_t;

  // Operand source, anything but MODE_REG means immediate
  typedef enum logic [3:0] {
    MODE_IMM = 4'd0,
    MODE_REG = 4'd1
  } mode_t;

  // Four steps per instruction
  typedef enum logic [1:0] {
    FETCH      = 2'b00,
    DECODE     = 2'b01,
    EXEC       = 2'b10,
    WRITE_BACK = 2'b11
  } state_t;

endpackage

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int STACK_DEPTH = 4
)
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [PADDR_W-1:0] wb_adr,
  input  logic [INSTR_W-1:0] wb_dat_w,
  output logic               wb_ack,
  output logic [PADDR_W-1:0] pc,
  output logic [DATA_W-1:0]  acc,
  output logic               retire,
  output logic               stack_full,
  output logic               stack_empty
);

  //////////////////////////////
  // Internal nets
  //////////////////////////////

  logic [INSTR_W-1:0] instr;
  opcode_t            alu_op;
  logic               use_imm;
  logic [DATA_W-1:0]  imm;
  logic               acc_we;
  logic [RADDR_W-1:0] rf_addr;
  logic               rf_we;
  logic [DATA_W-1:0]  rf_rdata;
  logic               push;
  logic               pop;
  logic [PADDR_W-1:0] push_addr;
  logic [PADDR_W-1:0] top_addr;

  // Program loader and fetch port
  prog_mem u_prog_mem (
    .clk      (clk),
    .rstn     (rstn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .pc       (pc),
    .wb_ack   (wb_ack),
    .instr    (instr)
  );

  // Any open bus cycle stalls execution
  seq_control u_seq_control (
    .clk       (clk),
    .rstn      (rstn),
    .hold      (wb_cyc),
    .instr     (instr),
    .top_addr  (top_addr),
    .empty     (stack_empty),
    .pc        (pc),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .imm       (imm),
    .acc_we    (acc_we),
    .rf_addr   (rf_addr),
    .rf_we     (rf_we),
    .push      (push),
    .push_addr (push_addr),
    .pop       (pop),
    .retire    (retire)
  );

  exec_unit u_exec_unit (
    .clk      (clk),
    .rstn     (rstn),
    .alu_op   (alu_op),
    .use_imm  (use_imm),
    .imm      (imm),
    .rf_rdata (rf_rdata),
    .acc_we   (acc_we),
    .acc      (acc)
  );

  // ST writes the accumulator into register b
  reg_file u_reg_file (
    .clk   (clk),
    .rstn  (rstn),
    .addr  (rf_addr),
    .we    (rf_we),
    .wdata (acc),
    .rdata (rf_rdata)
  );

  ret_stack #(
    .DEPTH (STACK_DEPTH)
  ) u_ret_stack (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .pop       (pop),
    .push_addr (push_addr),
    .top_addr  (top_addr),
    .full      (stack_full),
    .empty     (stack_empty)
  );

endmodule

//--- design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  opcode_t           alu_op,
  input  logic              use_imm,
  input  logic [DATA_W-1:0] imm,
  input  logic [DATA_W-1:0] rf_rdata,
  input  logic              acc_we,
  output logic [DATA_W-1:0] acc
);

  logic [DATA_W-1:0] operand;
  logic [DATA_W-1:0] result;

  // Immediate {a,b} or register b
  assign operand = use_imm ? imm : rf_rdata;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // No carry out, add and sub wrap at 256
  always_comb
  begin
    case (alu_op)
      OP_ADD:  result = acc + operand;
      OP_SUB:  result = acc - operand;
      OP_AND:  result = acc & operand;
      OP_OR:   result = acc | operand;
      OP_XOR:  result = acc ^ operand;
      // Load passes the operand straight through
      OP_LD:   result = operand;
      default: result = acc;
    endcase
  end

  //////////////////////////////
  // Accumulator
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      acc <= '0;
    end
    else if (acc_we)
    begin
      acc <= result;
    end
  end

endmodule

//--- design/prog_mem.sv
`timescale 1ns/1ps

module prog_mem
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [PADDR_W-1:0] wb_adr,
  input  logic [INSTR_W-1:0] wb_dat_w,
  input  logic [PADDR_W-1:0] pc,
  output logic               wb_ack,
  output logic [INSTR_W-1:0] instr
);

  localparam int DEPTH = 1 << PADDR_W;

  // Instruction storage, filled over the bus only
  logic [INSTR_W-1:0] mem [DEPTH];

  // New transfer seen this cycle; ack low keeps a held stb from double-acking
  logic xfer;

  assign xfer = wb_cyc && wb_stb && !wb_ack;

  //////////////////////////////
  // Bus side
  //////////////////////////////

  // One-cycle ack per classic transfer
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wb_ack <= 1'b0;
    end
    else
    begin
      wb_ack <= xfer;
    end
  end

  // Write lands on the same edge that raises ack
  // Reads (we low) are acked but return nothing
  always_ff @(posedge clk)
  begin
    if (xfer && wb_we)
    begin
      mem[wb_adr] <= wb_dat_w;
    end
  end

  // Fetch port, no read latency
  assign instr = mem[pc];

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic [RADDR_W-1:0] addr,
  input  logic               we,
  input  logic [DATA_W-1:0]  wdata,
  output logic [DATA_W-1:0]  rdata
);

  localparam int NREGS = 1 << RADDR_W;

  logic [DATA_W-1:0] regs [NREGS];

  // Single shared address for the read and the write
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      for (int i = 0; i < NREGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we)
    begin
      regs[addr] <= wdata;
    end
  end

  // Read is combinational, new data shows after the write edge
  assign rdata = regs[addr];

endmodule

//--- design/ret_stack.sv
`timescale 1ns/1ps

module ret_stack
  import cpu_pkg::*;
#(
  parameter int DEPTH = 4
)
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               push,
  input  logic               pop,
  input  logic [PADDR_W-1:0] push_addr,
  output logic [PADDR_W-1:0] top_addr,
  output logic               full,
  output logic               empty
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [PADDR_W-1:0] mem [DEPTH];
  // Number of valid entries
  logic [CNT_W-1:0]   count;
  logic [IDX_W-1:0]   top_idx;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign top_idx = IDX_W'(count - 1'b1);

  // Depth counter; push when full is dropped here
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      count <= '0;
    else if (push && !full)
      count <= count + 1'b1;
    else if (pop)
      count <= count - 1'b1;
  end

  // Return addresses
  always_ff @(posedge clk)
  begin
    if (push && !full)
      mem[IDX_W'(count)] <= push_addr;
  end

  // Newest entry or zero on an empty stack
  assign top_addr = empty ? '0 : mem[top_idx];

endmodule

//--- design/seq_control.sv
`timescale 1ns/1ps

module seq_control
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               hold,
  input  logic [INSTR_W-1:0] instr,
  input  logic [PADDR_W-1:0] top_addr,
  input  logic               empty,
  output logic [PADDR_W-1:0] pc,
  output opcode_t            alu_op,
  output logic               use_imm,
  output logic [DATA_W-1:0]  imm,
  output logic               acc_we,
  output logic [RADDR_W-1:0] rf_addr,
  output logic               rf_we,
  output logic               push,
  output logic [PADDR_W-1:0] push_addr,
  output logic               pop,
  output logic               retire
);

  state_t             state;
  logic [INSTR_W-1:0] ir;
  opcode_t            op_q;
  logic               use_imm_q;
  logic [DATA_W-1:0]  imm_q;
  logic [PADDR_W-1:0] next_pc_q;

  // Fields of the latched word
  opcode_t            dec_op;
  mode_t              dec_mode;
  logic [PADDR_W-1:0] field_a;
  logic [PADDR_W-1:0] dec_next_pc;
  logic               run;

  // Bus activity freezes the whole sequencer
  assign run = !hold;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign dec_mode = mode_t'(ir[11:8]);
  assign field_a  = ir[7:4];

  // Unused opcodes collapse to NOP
  always_comb
  begin
    case (opcode_t'(ir[15:12]))
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_LD, OP_ST, OP_JMP, OP_RTN:
        dec_op = opcode_t'(ir[15:12]);
      default:
        dec_op = OP_NOP;
    endcase
  end

  // Next pc is settled in DECODE, before the pop moves the stack top
  always_comb
  begin
    if (dec_op == OP_JMP)
      dec_next_pc = field_a;
    else if (dec_op == OP_RTN && !empty)
      dec_next_pc = top_addr + 1'b1;
    else
      dec_next_pc = pc + 1'b1;
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state <= FETCH;
      pc    <= '0;
      op_q  <= OP_NOP;
    end
    else if (run)
    begin
      case (state)
        FETCH:      state <= DECODE;
        DECODE:
        begin
          op_q  <= dec_op;
          state <= EXEC;
        end
        EXEC:       state <= WRITE_BACK;
        WRITE_BACK:
        begin
          pc    <= next_pc_q;
          state <= FETCH;
        end
        default:    state <= FETCH;
      endcase
    end
  end

  // Instruction word and decoded payload
  always_ff @(posedge clk)
  begin
    if (run && state == FETCH)
    begin
      ir <= instr;
    end
    if (run && state == DECODE)
    begin
      // MODE_IMM and every unknown mode take the immediate
      use_imm_q <= (dec_mode != MODE_REG);
      imm_q     <= ir[7:0];
      next_pc_q <= dec_next_pc;
    end
  end

  //////////////////////////////
  // Strobes
  //////////////////////////////

  // ALU ops and LD write the accumulator; ST reg writes register b
  always_comb
  begin
    case (op_q)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LD:
        acc_we = run && state == EXEC;
      default:
        acc_we = 1'b0;
    endcase
  end

  assign rf_we  = run && state == EXEC && op_q == OP_ST && !use_imm_q;
  assign push   = run && state == EXEC && op_q == OP_JMP;
  // Empty stack turns RTN into a plain step
  assign pop    = run && state == DECODE && dec_op == OP_RTN && !empty;
  assign retire = run && state == WRITE_BACK;

  assign alu_op    = op_q;
  assign use_imm   = use_imm_q;
  assign imm       = imm_q;
  // Register operand is field b
  assign rf_addr   = imm_q[RADDR_W-1:0];
  assign push_addr = pc;

endmodule

//--- tb.f
design/cpu_pkg.sv
design/prog_mem.sv
design/seq_control.sv
design/exec_unit.sv
design/reg_file.sv
design/ret_stack.sv
design/cpu_top.sv
verif/tb_cpu.sv

//--- verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
  import cpu_pkg::*;
;

  localparam int STACK_DEPTH    = 4;
  localparam int ACK_TIMEOUT    = 16;
  localparam int RETIRE_TIMEOUT = 32;

  logic               clk = 1'b0;
  logic               rstn;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [PADDR_W-1:0] wb_adr;
  logic [INSTR_W-1:0] wb_dat_w;
  logic               wb_ack;
  logic [PADDR_W-1:0] pc;
  logic [DATA_W-1:0]  acc;
  logic               retire;
  logic               stack_full;
  logic               stack_empty;

  // Image being built for the next load and what the memory really holds
  logic [INSTR_W-1:0] image [16];
  logic [INSTR_W-1:0] prog [16];

  // ISA model state
  logic [PADDR_W-1:0] m_pc;
  logic [DATA_W-1:0]  m_acc;
  logic [DATA_W-1:0]  m_regs [16];
  logic [PADDR_W-1:0] m_stk [STACK_DEPTH];
  int                 m_depth;

  int seed;
  int error_count  = 0;
  int test_count   = 0;
  int retire_count = 0;

  always #50 clk = ~clk;

  cpu_top #(
    .STACK_DEPTH (STACK_DEPTH)
  ) u_cpu_top (
    .clk         (clk),
    .rstn        (rstn),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_ack      (wb_ack),
    .pc          (pc),
    .acc         (acc),
    .retire      (retire),
    .stack_full  (stack_full),
    .stack_empty (stack_empty)
  );

  //////////////////////////////
  // ISA model stepped on each retire
  //////////////////////////////

  always @(posedge clk or negedge rstn)
  begin : isa_model
    logic [INSTR_W-1:0] w;
    logic [3:0]         op;
    logic [3:0]         md;
    logic [DATA_W-1:0]  opnd;
    if (!rstn)
    begin
      m_pc    <= '0;
      m_acc   <= '0;
      m_depth <= 0;
      for (int i = 0; i < 16; i++)
        m_regs[i] <= '0;
    end
    else if (retire)
    begin
      w    = prog[m_pc];
      op   = w[15:12];
      md   = w[11:8];
      // Anything but register mode reads the immediate {a,b}
      opnd = (md == MODE_REG) ? m_regs[w[3:0]] : w[7:0];
      m_pc <= m_pc + 1'b1;
      retire_count <= retire_count + 1;
      case (op)
        OP_ADD: m_acc <= m_acc + opnd;
        OP_SUB: m_acc <= m_acc - opnd;
        OP_AND: m_acc <= m_acc & opnd;
        OP_OR:  m_acc <= m_acc | opnd;
        OP_XOR: m_acc <= m_acc ^ opnd;
        OP_LD:  m_acc <= opnd;
        OP_ST:
          if (md == MODE_REG)
            m_regs[w[3:0]] <= m_acc;
        OP_JMP:
        begin
          // Full stack loses the return address but the jump is still taken
          if (m_depth < STACK_DEPTH)
          begin
            m_stk[m_depth] <= m_pc;
            m_depth        <= m_depth + 1;
          end
          m_pc <= w[7:4];
        end
        OP_RTN:
          if (m_depth > 0)
          begin
            m_pc    <= m_stk[m_depth-1] + 1'b1;
            m_depth <= m_depth - 1;
          end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // Bus handshake
  a_ack_next : assert property (@(posedge clk) disable iff (!rstn)
    wb_cyc && wb_stb && !wb_ack |=> wb_ack)
    else report_mismatch("no wb_ack one cycle after the request");
  a_ack_once : assert property (@(posedge clk) disable iff (!rstn)
    wb_ack |=> !wb_ack)
    else report_mismatch("wb_ack longer than one cycle");
  a_ack_cyc : assert property (@(posedge clk) disable iff (!rstn)
    wb_ack |-> wb_cyc)
    else report_mismatch("wb_ack without wb_cyc");

  // Stall and instruction rhythm
  a_stall_retire : assert property (@(posedge clk) disable iff (!rstn)
    wb_cyc |-> !retire)
    else report_mismatch("retire while wb_cyc is high");
  a_stall_stable : assert property (@(posedge clk) disable iff (!rstn)
    wb_cyc |=> $stable(pc) && $stable(acc))
    else report_mismatch("pc or acc moved during a stall");
  a_retire_gap : assert property (@(posedge clk) disable iff (!rstn)
    retire |=> !retire [*3])
    else report_mismatch("retire closer than four cycles");
  a_retire_period : assert property (@(posedge clk) disable iff (!rstn)
    retire ##1 !wb_cyc [*4] |-> retire)
    else report_mismatch("retire missing four cycles after the last one");

  // Architectural state against the model
  a_acc_value : assert property (@(posedge clk) disable iff (!rstn)
    retire |=> acc == m_acc)
    else report_mismatch($sformatf("acc %0h, model %0h", $sampled(acc), $sampled(m_acc)));
  a_pc_value : assert property (@(posedge clk) disable iff (!rstn)
    retire |=> pc == m_pc)
    else report_mismatch($sformatf("pc %0d, model %0d", $sampled(pc), $sampled(m_pc)));
  a_stack_flags : assert property (@(posedge clk) disable iff (!rstn)
    retire |=> stack_empty == (m_depth == 0) && stack_full == (m_depth == STACK_DEPTH))
    else report_mismatch($sformatf("stack flags wrong at model depth %0d", $sampled(m_depth)));

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Bus stays open through reset so nothing runs on an unloaded memory
  task automatic apply_reset();
    @(posedge clk);
    rstn   <= 1'b0;
    wb_cyc <= 1'b1;
    wb_stb <= 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
  endtask

  // One classic transfer with stb held until ack and cyc left to the caller
  task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [15:0] data);
    int waited;
    @(posedge clk);
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    waited = 0;
    @(negedge clk);
    while (!wb_ack && waited < ACK_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack)
    begin
      $display("Timeout: no wb_ack for the bus cycle to address %0d", adr);
      $display("CHECKS FAILED");
      $finish;
    end
    else
    begin
      @(posedge clk);
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      if (we)
        prog[adr] = data;
    end
  endtask

  // A strobe with cyc low must be ignored while the CPU runs
  task automatic stray_strobe(input int cycles);
    @(posedge clk);
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= 4'd5;
    wb_dat_w <= {OP_LD, MODE_IMM, 8'h5a};
    repeat (cycles) @(posedge clk);
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < 16; i++)
      bus_cycle(1'b1, 4'(i), image[i]);
  endtask

  // Unused opcodes 10..15 with fields taken from the address
  task automatic fill_image();
    for (int i = 0; i < 16; i++)
      image[i] = {4'(10 + i % 6), 4'(i), 4'(i) ^ 4'h5, ~4'(i)};
  endtask

  function automatic opcode_t pick_alu_op(input int k);
    case (k % 6)
      0:       return OP_LD;
      1:       return OP_ADD;
      2:       return OP_SUB;
      3:       return OP_AND;
      4:       return OP_OR;
      default: return OP_XOR;
    endcase
  endfunction

  function automatic logic [15:0] reg_instr(input opcode_t op, input logic [3:0] r);
    return {op, MODE_REG, 4'h0, r};
  endfunction

  // Random immediates; every fifth word uses an unknown mode value
  task automatic build_alu_imm();
    logic [7:0] v;
    for (int i = 0; i < 16; i++)
    begin
      v = 8'($random(seed));
      image[i] = {pick_alu_op(i), (i % 5 == 4) ? 4'hC : 4'h0, v};
    end
  endtask

  // Releases the bus, counts n retires, then stalls again
  task automatic run_retires(input int n);
    int seen;
    int idle;
    @(posedge clk);
    wb_cyc <= 1'b0;
    seen = 0;
    idle = 0;
    while (seen < n && idle < RETIRE_TIMEOUT)
    begin
      @(negedge clk);
      if (retire)
      begin
        seen++;
        idle = 0;
      end
      else
        idle++;
    end
    if (seen < n)
    begin
      $display("Timeout: only %0d of %0d retire pulses arrived", seen, n);
      $display("CHECKS FAILED");
      $finish;
    end
    else
    begin
      @(posedge clk);
      wb_cyc <= 1'b1;
    end
  endtask

  // Runs freely for a while, then holds cyc without a transfer
  task automatic pause(input int run_cycles, input int hold_cycles);
    @(posedge clk);
    wb_cyc <= 1'b0;
    repeat (run_cycles) @(posedge clk);
    wb_cyc <= 1'b1;
    repeat (hold_cycles) @(posedge clk);
  endtask

  task automatic test_done(input string name, input int errs_before);
    repeat (2) @(posedge clk);
    test_count++;
    $display("test %s done, %0d errors", name, error_count - errs_before);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    int errs;
    logic [7:0] v;
    seed     = 32'hb759_4062;
    rstn     = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;

    // ALU ops in immediate mode twice round so pc wraps
    errs = error_count;
    apply_reset();
    build_alu_imm();
    load_program();
    run_retires(32);
    test_done("alu_imm", errs);

    // Register mode, ST/LD round trip, ST imm as NOP
    errs = error_count;
    apply_reset();
    v = 8'($random(seed));
    image[0]  = {OP_LD, MODE_IMM, v};
    image[1]  = reg_instr(OP_ST, 4'd3);
    v = 8'($random(seed));
    image[2]  = {OP_LD, MODE_IMM, v};
    image[3]  = reg_instr(OP_ST, 4'd7);
    v = 8'($random(seed));
    image[4]  = {OP_LD, MODE_IMM, v};
    image[5]  = reg_instr(OP_ST, 4'd12);
    image[6]  = reg_instr(OP_ADD, 4'd3);
    image[7]  = reg_instr(OP_SUB, 4'd7);
    image[8]  = reg_instr(OP_XOR, 4'd12);
    image[9]  = {OP_ST, MODE_IMM, 8'h03};
    image[10] = reg_instr(OP_LD, 4'd3);
    image[11] = reg_instr(OP_AND, 4'd12);
    image[12] = reg_instr(OP_OR, 4'd7);
    image[13] = reg_instr(OP_ST, 4'd0);
    image[14] = reg_instr(OP_LD, 4'd12);
    image[15] = reg_instr(OP_ADD, 4'd0);
    load_program();
    // A read cycle is acked and must not touch word 10
    bus_cycle(1'b0, 4'd10, 16'hffff);
    run_retires(32);
    test_done("alu_reg", errs);

    // Nested jumps past the stack depth and returns down to an empty stack
    errs = error_count;
    apply_reset();
    fill_image();
    for (int i = 0; i < 10; i += 2)
      image[i] = {OP_JMP, MODE_IMM, 4'(i + 2), 4'h0};
    for (int i = 1; i < 8; i += 2)
      image[i] = {OP_RTN, MODE_IMM, 8'h00};
    image[10] = {OP_RTN, MODE_IMM, 8'h00};
    v = 8'($random(seed));
    image[9]  = {OP_ADD, MODE_IMM, v};
    load_program();
    run_retires(24);
    test_done("jump_return", errs);

    // Stalls between and inside instructions
    errs = error_count;
    apply_reset();
    build_alu_imm();
    load_program();
    run_retires(2);
    pause(6, 5);
    pause(1, 3);
    pause(11, 4);
    run_retires(10);
    test_done("stall", errs);

    // Nothing but unused opcodes and a strobe without cyc
    errs = error_count;
    apply_reset();
    fill_image();
    load_program();
    stray_strobe(6);
    run_retires(20);
    test_done("unused_ops", errs);

    repeat (4) @(posedge clk);
    $display("tests %0d, retires %0d, errors %0d", test_count, retire_count, error_count);
    if (error_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
